// ==== verilog.f ====
verilog/rv_pkg.sv
verilog/rv_sequencer.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_store_unit.sv
verilog/rv_core.sv
testbench/tb_mem.sv
testbench/tb_core.sv

// ==== testbench/tb_core.sv ====
module tb_core;
  import rv_pkg::*;

  localparam word_t RESET_PC = 32'h0000_0000;
  localparam word_t EBREAK   = 32'h0010_0073;

  logic  clk;
  logic  rst_n;
  logic  iwb_cyc;
  logic  iwb_stb;
  logic  iwb_ack;
  logic  dwb_cyc;
  logic  dwb_stb;
  logic  dwb_ack;
  logic  halt;
  word_t iwb_adr;
  word_t iwb_dat;
  word_t dwb_adr;
  word_t dwb_dat;

  word_t exp_pc [0:255];
  word_t exp_adr [0:63];
  word_t exp_dat [0:63];
  word_t mreg [0:31];  // Register values the program should produce
  int    n_pc;
  int    n_st;
  int    n_prog;
  int    fetch_n;
  int    errors;
  word_t pc;
  word_t off;
  word_t rnd;
  bit    timed_out;

  rv_core #(.RESET_PC(RESET_PC)) dut0 (
    .clk(clk), .rst_n_i(rst_n),
    .iwb_cyc_o(iwb_cyc), .iwb_stb_o(iwb_stb), .iwb_adr_o(iwb_adr),
    .iwb_dat_i(iwb_dat), .iwb_ack_i(iwb_ack),
    .dwb_cyc_o(dwb_cyc), .dwb_stb_o(dwb_stb), .dwb_adr_o(dwb_adr),
    .dwb_dat_o(dwb_dat), .dwb_ack_i(dwb_ack), .halt_o(halt)
  );

  tb_mem mem0 (
    .clk(clk), .rst_n_i(rst_n),
    .iwb_cyc_i(iwb_cyc), .iwb_stb_i(iwb_stb), .iwb_adr_i(iwb_adr),
    .iwb_dat_o(iwb_dat), .iwb_ack_o(iwb_ack),
    .dwb_cyc_i(dwb_cyc), .dwb_stb_i(dwb_stb), .dwb_adr_i(dwb_adr),
    .dwb_dat_i(dwb_dat), .dwb_ack_o(dwb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_n <= 0;
    end else if (iwb_stb && iwb_ack) begin
      fetch_n <= fetch_n + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  assert property (@(posedge clk) !rst_n |-> !iwb_cyc && !dwb_cyc && !halt)
    else begin
      errors++;
      $display("%0t: a bus cycle or halt is active in reset", $time);
    end
  assert property (@(posedge clk) disable iff (!rst_n) iwb_stb && iwb_ack |->
    fetch_n < n_pc && iwb_adr == exp_pc[fetch_n])
    else begin
      errors++;
      $display("ERR %0t iwb_adr_o exp %h got %h", $time, exp_pc[$sampled(fetch_n)],
               $sampled(iwb_adr));
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    iwb_cyc == iwb_stb && dwb_cyc == dwb_stb)
    else begin
      errors++;
      $display("%0t: cyc and stb differ", $time);
    end
  assert property (@(posedge clk) disable iff (!rst_n) !(iwb_cyc && dwb_cyc))
    else begin
      errors++;
      $display("%0t: both buses hold cyc at once", $time);
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    iwb_stb && !iwb_ack |=> $stable(iwb_adr))
    else begin
      errors++;
      $display("ERR %0t iwb_adr_o exp %h got %h", $time, $past(iwb_adr), iwb_adr);
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    dwb_stb && !dwb_ack |=> $stable(dwb_adr))
    else begin
      errors++;
      $display("ERR %0t dwb_adr_o exp %h got %h", $time, $past(dwb_adr), dwb_adr);
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    dwb_stb && !dwb_ack |=> $stable(dwb_dat))
    else begin
      errors++;
      $display("ERR %0t dwb_dat_o exp %h got %h", $time, $past(dwb_dat), dwb_dat);
    end
  assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt && !iwb_cyc && !dwb_cyc)
    else begin
      errors++;
      $display("%0t: bus activity or halt drop after halt", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Program builder

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t r_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    inst_u u;
    u.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
    return word_t'(u);
  endfunction

  function automatic word_t i_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd);
    inst_u u;
    u.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
    return word_t'(u);
  endfunction

  function automatic word_t sw_word(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    inst_u u;
    u.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: F3_SW, imm_lo: imm[4:0],
            opcode: OPC_STORE};
    return word_t'(u);
  endfunction

  function automatic word_t b_word(logic [12:0] ofs, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    inst_u u;
    u.b = '{imm12: ofs[12], imm10_5: ofs[10:5], rs2: rs2, rs1: rs1, funct3: f3,
            imm4_1: ofs[4:1], imm11: ofs[11], opcode: OPC_BRANCH};
    return word_t'(u);
  endfunction

  function automatic word_t lui_word(logic [19:0] imm, reg_idx_t rd);
    inst_u u;
    u.u = '{imm: imm, rd: rd, opcode: OPC_LUI};
    return word_t'(u);
  endfunction

  // RV32I arithmetic by funct3 where alt stands for funct7 bit 5
  function automatic word_t calc(logic [2:0] f3, bit alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(word_t w, bit runs);
    mem0.prog[pc[9:2]] = w;
    if (runs) begin
      exp_pc[n_pc] = pc;
      n_pc++;
    end
    pc += 4;
    n_prog++;
  endtask

  task automatic load_const(reg_idx_t rd, word_t val);
    word_t hi;
    hi = (val + 32'h800) >> 12;
    emit(lui_word(hi[19:0], rd), 1);
    emit(i_word(val[11:0], rd, F3_ADD, rd), 1);
    mreg[rd] = val;
  endtask

  task automatic store(reg_idx_t rs2, bit runs);
    emit(sw_word(off[11:0], rs2, 5'd10), runs);
    if (runs) begin
      exp_adr[n_st] = mreg[10] + off;
      exp_dat[n_st] = mreg[rs2];
      n_st++;
    end
    off += 4;  // Skipped stores still get their own address
  endtask

  task automatic imm_op(logic [2:0] f3, bit alt, reg_idx_t rs1);
    logic [11:0] imm;
    rnd = xorshift(rnd);
    imm = (f3 == F3_SLL || f3 == F3_SR) ? {1'b0, alt, 5'b0, rnd[4:0]} : rnd[11:0];
    mreg[5] = calc(f3, alt, mreg[rs1], {{20{imm[11]}}, imm});
    emit(i_word(imm, rs1, f3, 5'd5), 1);
    store(5'd5, 1);
  endtask

  task automatic reg_op(logic [2:0] f3, bit alt, reg_idx_t rs1, reg_idx_t rs2);
    mreg[5] = calc(f3, alt, mreg[rs1], mreg[rs2]);
    emit(r_word(alt ? 7'h20 : 7'h00, rs2, rs1, f3, 5'd5), 1);
    store(5'd5, 1);
  endtask

  task automatic branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
    bit taken;
    taken = (f3 == F3_BEQ) == (mreg[rs1] == mreg[rs2]);
    emit(b_word(13'd8, rs2, rs1, f3), 1);
    store(5'd1, !taken);
  endtask

  task automatic build_program(word_t last);
    word_t v;
    for (int i = 0; i < 256; i++) mem0.prog[i] = {16'(i), 16'h007f};  // Unknown opcodes
    for (int i = 0; i < 32; i++) mreg[i] = '0;
    pc = RESET_PC;
    off = '0;
    n_pc = 0;
    n_st = 0;
    n_prog = 0;
    rnd = 32'h61de_ff83;
    load_const(5'd10, 32'h0000_1000);
    rnd = xorshift(rnd);
    load_const(5'd1, rnd & 32'h7fff_ffff);
    rnd = xorshift(rnd);
    load_const(5'd2, rnd);
    rnd = xorshift(rnd);
    load_const(5'd3, rnd | 32'h8000_0000);  // Negative operand
    for (int f = 0; f < 8; f++) imm_op(3'(f), 1'b0, (f == 5) ? 5'd3 : 5'd1);
    imm_op(F3_SR, 1'b1, 5'd3);
    for (int f = 0; f < 8; f++) begin
      reg_op(3'(f), 1'b0, 5'd1, 5'd3);
      reg_op(3'(f), 1'b0, 5'd3, 5'd2);
      if (f == 0 || f == 5) begin
        reg_op(3'(f), 1'b1, 5'd1, 5'd3);
        reg_op(3'(f), 1'b1, 5'd3, 5'd2);
      end
    end
    emit(i_word(12'h123, 5'd0, F3_ADD, 5'd0), 1);
    store(5'd0, 1);
    rnd = xorshift(rnd);
    v = rnd;
    load_const(5'd6, v);
    load_const(5'd7, v);
    load_const(5'd8, v ^ 32'h0000_0100);
    branch(F3_BEQ, 5'd6, 5'd7);
    branch(F3_BNE, 5'd6, 5'd8);
    branch(F3_BEQ, 5'd6, 5'd8);
    branch(F3_BNE, 5'd6, 5'd7);
    emit(last, 1);
  endtask

  task automatic run_program();
    int  limit;
    int  cycles;
    bit  halted;
    limit = n_prog * (3 + 3) * 2 + n_st * 4;
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    halted = 0;
    // Runs on to the limit so that any bus cycle after halt is caught
    while (cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (halt) halted = 1;
    end
    if (!halted) begin
      $display("Timeout: halt_o did not rise within %0d cycles", limit);
      timed_out = 1;
    end else begin
      assert (fetch_n == n_pc) else begin
        errors++;
        $display("The core made %0d fetches where %0d were expected", fetch_n, n_pc);
      end
      assert (mem0.n_log == n_st) else begin
        errors++;
        $display("The core made %0d stores where %0d were expected", mem0.n_log, n_st);
      end
      for (int i = 0; i < n_st && i < mem0.n_log; i++) begin
        assert (mem0.log_adr[i] == exp_adr[i]) else begin
          errors++;
          $display("ERR %0t dwb_adr_o exp %h got %h", $time, exp_adr[i], mem0.log_adr[i]);
        end
        assert (mem0.log_dat[i] == exp_dat[i]) else begin
          errors++;
          $display("ERR %0t dwb_dat_o exp %h got %h", $time, exp_dat[i], mem0.log_dat[i]);
        end
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    errors = 0;
    timed_out = 0;
    build_program(EBREAK);
    run_program();
    if (!timed_out) begin
      build_program(32'h0000_007f);  // Unknown opcode in place of EBREAK
      @(negedge clk);
      run_program();
    end
    $display("Errors: %0d", errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_mem.sv ====
module tb_mem (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          iwb_cyc_i,
  input  logic          iwb_stb_i,
  input  rv_pkg::word_t iwb_adr_i,
  output rv_pkg::word_t iwb_dat_o,
  output logic          iwb_ack_o,
  input  logic          dwb_cyc_i,
  input  logic          dwb_stb_i,
  input  rv_pkg::word_t dwb_adr_i,
  input  rv_pkg::word_t dwb_dat_i,
  output logic          dwb_ack_o
);
  import rv_pkg::*;

  word_t prog [0:255];     // Written by the testbench before each run
  word_t log_adr [0:63];
  word_t log_dat [0:63];
  int    n_log;
  word_t rnd;
  int    iwait;
  int    dwait;

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    iwb_dat_o = '0;
    iwb_ack_o = 1'b0;
    dwb_ack_o = 1'b0;
    n_log     = 0;
    rnd       = xorshift(32'h61de_ff83);
    iwait     = rnd[1:0];
    dwait     = rnd[3:2];
  end

  // Both buses share one random stream so the order of updates is fixed
  always @(negedge clk) begin
    iwb_ack_o <= 1'b0;
    dwb_ack_o <= 1'b0;
    if (!rst_n_i) begin
      n_log = 0;
    end else begin
      if (iwb_cyc_i && iwb_stb_i && !iwb_ack_o) begin
        if (iwait == 0) begin
          iwb_ack_o <= 1'b1;
          iwb_dat_o <= prog[iwb_adr_i[9:2]];
          rnd = xorshift(rnd);
          iwait = rnd[1:0];  // 0 to 3 wait cycles for the next fetch
        end else begin
          iwait--;
        end
      end
      if (dwb_cyc_i && dwb_stb_i && !dwb_ack_o) begin
        if (dwait == 0) begin
          dwb_ack_o <= 1'b1;
          log_adr[n_log] = dwb_adr_i;
          log_dat[n_log] = dwb_dat_i;
          n_log++;
          rnd = xorshift(rnd);
          dwait = rnd[1:0];
        end else begin
          dwait--;
        end
      end
    end
  end

endmodule

// ==== verilog/rv_core.sv ====
module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n_i,

  output logic          iwb_cyc_o,
  output logic          iwb_stb_o,
  output rv_pkg::word_t iwb_adr_o,
  input  rv_pkg::word_t iwb_dat_i,
  input  logic          iwb_ack_i,

  output logic          dwb_cyc_o,
  output logic          dwb_stb_o,
  output rv_pkg::word_t dwb_adr_o,
  output rv_pkg::word_t dwb_dat_o,
  input  logic          dwb_ack_i,

  output logic          halt_o
);
  import rv_pkg::*;

  word_t    inst;
  word_t    imm;
  word_t    rd1;
  word_t    rd2;
  word_t    alu_b;
  word_t    alu_result;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  alu_op_t  alu_op;
  logic     exec;
  logic     use_imm;
  logic     wb;
  logic     branch;
  logic     branch_ne;
  logic     store;
  logic     halt_req;
  logic     equal;
  logic     store_done;

  assign alu_b = use_imm ? imm : rd2;  // Second ALU operand

  rv_sequencer #(.RESET_PC(RESET_PC)) seq0 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .iwb_cyc_o    (iwb_cyc_o),
    .iwb_stb_o    (iwb_stb_o),
    .iwb_adr_o    (iwb_adr_o),
    .iwb_dat_i    (iwb_dat_i),
    .iwb_ack_i    (iwb_ack_i),
    .inst_o       (inst),
    .exec_o       (exec),
    .imm_i        (imm),
    .branch_i     (branch),
    .branch_ne_i  (branch_ne),
    .equal_i      (equal),
    .store_i      (store),
    .halt_i       (halt_req),
    .store_done_i (store_done),
    .halt_o       (halt_o)
  );

  rv_decode dec0 (
    .inst_i      (inst),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .use_imm_o   (use_imm),
    .wb_o        (wb),
    .branch_o    (branch),
    .branch_ne_o (branch_ne),
    .store_o     (store),
    .halt_o      (halt_req)
  );

  rv_regfile rf0 (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .rd_i    (rd),
    .we_i    (wb && exec),  // Write-back at the end of execute
    .wd_i    (alu_result),
    .rd1_o   (rd1),
    .rd2_o   (rd2)
  );

  rv_alu alu0 (
    .op_i     (alu_op),
    .a_i      (rd1),
    .b_i      (alu_b),
    .result_o (alu_result),
    .equal_o  (equal)
  );

  rv_store_unit st0 (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .start_i   (store && exec),
    .adr_i     (alu_result),
    .dat_i     (rd2),
    .dwb_cyc_o (dwb_cyc_o),
    .dwb_stb_o (dwb_stb_o),
    .dwb_adr_o (dwb_adr_o),
    .dwb_dat_o (dwb_dat_o),
    .dwb_ack_i (dwb_ack_i),
    .done_o    (store_done)
  );

endmodule

// ==== verilog/rv_store_unit.sv ====
module rv_store_unit (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  rv_pkg::word_t adr_i,
  input  rv_pkg::word_t dat_i,

  output logic          dwb_cyc_o,
  output logic          dwb_stb_o,
  output rv_pkg::word_t dwb_adr_o,
  output rv_pkg::word_t dwb_dat_o,
  input  logic          dwb_ack_i,

  output logic          done_o
);
  import rv_pkg::*;

  logic  cyc_q;
  word_t adr_q;
  word_t dat_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc_q <= 1'b0;
    end else if (start_i) begin
      cyc_q <= 1'b1;
    end else if (dwb_ack_i) begin
      cyc_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      adr_q <= adr_i;
      dat_q <= dat_i;
    end
  end

  assign dwb_cyc_o = cyc_q;
  assign dwb_stb_o = cyc_q;
  assign dwb_adr_o = adr_q;
  assign dwb_dat_o = dat_q;
  assign done_o    = cyc_q && dwb_ack_i;

  // The sequencer must not execute again before the write completes
  assert property (@(posedge clk) disable iff (!rst_n_i)
    start_i |-> !dwb_cyc_o);

  assert property (@(posedge clk) disable iff (!rst_n_i)
    dwb_stb_o && !dwb_ack_i |=> $stable(dwb_adr_o) && $stable(dwb_dat_o));

endmodule

// ==== verilog/rv_alu.sv ====
module rv_alu (
  input  rv_pkg::alu_op_t op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o,
  output logic            equal_o
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;  // Also the store address
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU:   result_o = {31'b0, a_i < b_i};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // Branches run with both operands from the register file
  assign equal_o = (a_i == b_i);

endmodule

// ==== verilog/rv_regfile.sv ====
module rv_regfile (
  input  logic             clk,
  input  logic             rst_n_i,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  logic             we_i,
  input  rv_pkg::word_t    wd_i,
  output rv_pkg::word_t    rd1_o,
  output rv_pkg::word_t    rd2_o
);
  import rv_pkg::*;

  word_t regs_q [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= wd_i;
    end
  end

  assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// ==== verilog/rv_decode.sv ====
module rv_decode (
  input  rv_pkg::word_t    inst_i,
  output rv_pkg::reg_idx_t rs1_o,
  output rv_pkg::reg_idx_t rs2_o,
  output rv_pkg::reg_idx_t rd_o,
  output rv_pkg::word_t    imm_o,
  output rv_pkg::alu_op_t  alu_op_o,
  output logic             use_imm_o,
  output logic             wb_o,
  output logic             branch_o,
  output logic             branch_ne_o,
  output logic             store_o,
  output logic             halt_o
);
  import rv_pkg::*;

  inst_u inst;
  word_t imm_i_fmt;
  word_t imm_s_fmt;
  word_t imm_b_fmt;
  word_t imm_u_fmt;

  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign inst = inst_i;

  assign rs1_o = inst.r.rs1;
  assign rs2_o = inst.r.rs2;
  assign rd_o  = inst.r.rd;

  assign imm_i_fmt = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s_fmt = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b_fmt = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                      inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_u_fmt = {inst.u.imm, 12'h000};

  always_comb begin
    imm_o       = imm_i_fmt;
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    wb_o        = 1'b0;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;
    store_o     = 1'b0;
    halt_o      = 1'b0;
    case (inst.r.opcode)
      OPC_OP: begin
        alu_op_o = alu_from_f3(inst.r.funct3, inst.r.funct7[5]);
        wb_o     = 1'b1;
      end
      OPC_OP_IMM: begin
        // Bit 30 only selects SRAI here, ADDI keeps it as immediate
        alu_op_o  = alu_from_f3(inst.i.funct3,
                                inst.i.funct3 == F3_SR && inst.r.funct7[5]);
        use_imm_o = 1'b1;
        wb_o      = 1'b1;
      end
      OPC_LUI: begin
        imm_o     = imm_u_fmt;
        alu_op_o  = ALU_PASS_B;
        use_imm_o = 1'b1;
        wb_o      = 1'b1;
      end
      OPC_BRANCH: begin
        imm_o       = imm_b_fmt;  // ALU compares rs1 with rs2
        branch_o    = (inst.b.funct3 == F3_BEQ) || (inst.b.funct3 == F3_BNE);
        branch_ne_o = (inst.b.funct3 == F3_BNE);
        halt_o      = !branch_o;
      end
      OPC_STORE: begin
        imm_o     = imm_s_fmt;
        use_imm_o = 1'b1;
        store_o   = (inst.s.funct3 == F3_SW);
        halt_o    = !store_o;  // Byte and halfword stores are not supported
      end
      OPC_SYSTEM: begin
        halt_o = 1'b1;  // EBREAK, and ECALL or CSR access stop the core as well
      end
      default: begin
        halt_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== verilog/rv_sequencer.sv ====
module rv_sequencer #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n_i,

  output logic          iwb_cyc_o,
  output logic          iwb_stb_o,
  output rv_pkg::word_t iwb_adr_o,
  input  rv_pkg::word_t iwb_dat_i,
  input  logic          iwb_ack_i,

  output rv_pkg::word_t inst_o,
  output logic          exec_o,
  input  rv_pkg::word_t imm_i,
  input  logic          branch_i,
  input  logic          branch_ne_i,
  input  logic          equal_i,
  input  logic          store_i,
  input  logic          halt_i,
  input  logic          store_done_i,
  output logic          halt_o
);
  import rv_pkg::*;

  localparam logic [1:0] S_FETCH = 2'd0;
  localparam logic [1:0] S_EXEC  = 2'd1;
  localparam logic [1:0] S_STORE = 2'd2;
  localparam logic [1:0] S_HALT  = 2'd3;

  logic [1:0] state_q;
  logic       cyc_q;
  word_t      pc_q;
  word_t      inst_q;
  word_t      pc_next;
  logic       taken;

  assign taken   = branch_i && (equal_i != branch_ne_i);
  assign pc_next = taken ? pc_q + imm_i : pc_q + 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch, execute, store

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_FETCH;
      cyc_q   <= 1'b0;
      pc_q    <= RESET_PC;
    end else begin
      case (state_q)
        S_FETCH: begin
          if (!cyc_q) begin
            cyc_q <= 1'b1;  // Only taken on the way out of reset
          end else if (iwb_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (halt_i) begin
            state_q <= S_HALT;
          end else begin
            pc_q <= pc_next;
            if (store_i) begin
              state_q <= S_STORE;
            end else begin
              state_q <= S_FETCH;
              cyc_q   <= 1'b1;
            end
          end
        end
        S_STORE: begin
          if (store_done_i) begin
            state_q <= S_FETCH;
            cyc_q   <= 1'b1;
          end
        end
        default: begin
          state_q <= S_HALT;  // Stays here until reset
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cyc_q && iwb_ack_i) begin
      inst_q <= iwb_dat_i;
    end
  end

  assign iwb_cyc_o = cyc_q;
  assign iwb_stb_o = cyc_q;
  assign iwb_adr_o = pc_q;
  assign inst_o    = inst_q;
  assign exec_o    = (state_q == S_EXEC);
  assign halt_o    = (state_q == S_HALT);

  ////////////////////////////////////////////////////////////////////////////
  // Bus checks

  // A waiting fetch keeps its address
  assert property (@(posedge clk) disable iff (!rst_n_i)
    iwb_stb_o && !iwb_ack_i |=> $stable(iwb_adr_o));

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and function codes

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA, picked by funct7 bit 5
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_SW   = 3'b010;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats, all views of the same 32-bit word

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } inst_u;

endpackage
